/* dv/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
    input  logic          CLK,
    input  logic          RESET,
    input  cpuPkg::addrT  busAddr,
    input  logic          busWe,
    input  cpuPkg::irqT   irqAck
);

    // Read back by the testbench at the end of the run
    int failCount = 0;

    // One strobe per write
    weSingle: assert property (@(posedge CLK) disable iff (RESET) busWe |=> !busWe)
        else begin
            failCount++;
            $error("busWe stayed high for a second cycle");
        end

    // Ack names exactly one line
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET)
        irqAck != '0 |-> $onehot(irqAck))
        else begin
            failCount++;
            $error("irqAck has more than one line set: %b", irqAck);
        end

    ackSingle: assert property (@(posedge CLK) disable iff (RESET) irqAck != '0 |=> irqAck == '0)
        else begin
            failCount++;
            $error("irqAck stayed high for a second cycle");
        end

    // Accesses never sit back to back, so the address drops to FF right after one
    addrIdle: assert property (@(posedge CLK) disable iff (RESET)
        busAddr != 8'hFF |=> busAddr == 8'hFF)
        else begin
            failCount++;
            $error("busAddr not back to FF after an access");
        end

endmodule

bind microProcessor cpu_checker cpuChecker_i (
    .CLK(CLK), .RESET(RESET), .busAddr(busAddr), .busWe(busWe), .irqAck(irqAck)
);

/* dv/cpu_golden.hex */
// ROM @000, RAM @100, IRQ schedule @200 (count, instructions, then raise ack writes)
// Writes @300: count, then address, ALU op (FF for literal data) and data per write
@000
00 20 02 30 01 21 03 31 08 02 3F 08 08 08 08 08
01 11 00 10 04 02 60 00 10 14 02 61 00 10 24 02
62 00 10 34 02 63 00 10 44 02 64 00 10 54 02 65
00 10 64 02 66 00 10 74 02 67 00 10 94 02 69 00
10 A4 02 6A 00 10 B4 02 6B 00 10 F4 02 6F 15 03
70 00 12 01 13 96 59 02 3E A6 7E B6 7E 02 50 01
10 96 7E A6 7E B6 69 02 3D 00 10 01 12 B6 7E A6
73 03 3C 03 51 07 79 02 3B 02 52 0F 02 3A 02 3F
08
@0FE
10 00
@110
C6 5B 5A 5A
@120
6B 94
@200
03 46 01 01 02 02 02 10 03 01 02
@300
14
30 FF 6B 31 FF 94
60 00 00 61 01 00 62 02 00 63 03 00 64 04 00 65 05 00 66 06 00 67 07 00
69 09 00 6A 0A 00 6B 0B 00 6F 0F 00 70 01 00
50 FF 5A 51 FF 5A 52 FF C6
30 FF 6B 31 FF 94

/* dv/tbMicroProcessor.sv */
`timescale 1ns/1ps

module tbMicroProcessor;

    logic CLK;
    logic RESET;
    cpuPkg::addrT romAddr;
    cpuPkg::dataT romData;
    cpuPkg::addrT busAddr;
    cpuPkg::dataT busDataIn;
    cpuPkg::dataT busDataOut;
    logic busWe;
    cpuPkg::irqT irqRaise;
    cpuPkg::irqT irqAck;

    // Golden image, ROM at 000, RAM at 100, schedule at 200, writes at 300
    logic [7:0] golden [0:1023];
    logic [7:0] rom [0:256-1];
    logic [7:0] ram [0:256-1];
    int errors = 0;
    int writeCount = 0;
    int writeTotal = 0;
    int limitCycles = 0;
    bit loaded = 1'b0;
    logic [31:0] rngState;

    microProcessor microProcessor_i (
        .CLK(CLK), .RESET(RESET), .romAddr(romAddr), .romData(romData),
        .busAddr(busAddr), .busDataIn(busDataIn), .busDataOut(busDataOut), .busWe(busWe),
        .irqRaise(irqRaise), .irqAck(irqAck)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    //////////////////////////////
    // Reference rules

    function automatic logic [7:0] aluModel(input logic [7:0] op, input logic [7:0] a,
                                            input logic [7:0] b);
        case (op)
            8'h0: return a + b;
            8'h1: return a - b;
            8'h2: return a & b;
            8'h3: return a | b;
            8'h4: return a ^ b;
            8'h5: return a + 8'd1;
            8'h6: return b + 8'd1;
            8'h9: return (a == b) ? 8'd1 : 8'd0;
            8'hA: return (a > b) ? 8'd1 : 8'd0;
            8'hB: return (a < b) ? 8'd1 : 8'd0;
            // Everything else passes A
            default: return a;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Compare one bus write with the next golden entry
    task automatic checkWrite(input logic [7:0] addr, input logic [7:0] data);
        int base;
        logic [7:0] expData;
        base = 'h301 + 3 * writeCount;
        ram[addr] = data;
        assert (writeCount < writeTotal) else begin
            errors++;
            $display("Bus write of %h to %h came after the last expected write", data, addr);
        end
        if (writeCount < writeTotal) begin
            // Maths results use the golden RAM operands at 10 and 11
            expData = (golden[base + 1] == 8'hFF) ? golden[base + 2]
                    : aluModel(golden[base + 1], golden['h110], golden['h111]);
            checkValue($sformatf("write %0d address", writeCount), golden[base], addr);
            checkValue($sformatf("write %0d data", writeCount), expData, data);
        end
        writeCount++;
    endtask

    // Core sits idle, no access and no ack
    task automatic idleCycles(input int n, input string name);
        repeat (n) begin
            @(negedge CLK);
            checkValue({name, " busWe"}, 8'h00, 8'(busWe));
            checkValue({name, " busAddr"}, 8'hFF, busAddr);
            checkValue({name, " irqAck"}, 8'h00, 8'(irqAck));
        end
    endtask

    //////////////////////////////
    // Synchronous ROM and RAM, answers 1 ns after the edge
    always @(posedge CLK) begin
        cpuPkg::addrT romSample;
        cpuPkg::addrT busSample;
        romSample = romAddr;
        busSample = busAddr;
        if (busWe && !RESET)
            checkWrite(busSample, busDataOut);
        #1;
        romData = rom[romSample];
        busDataIn = ram[busSample];
    end

    initial begin
        int irqCount;
        int base;
        int gap;
        int target;
        int checkerFails;
        RESET = 1'b1;
        irqRaise = '0;
        romData = '0;
        busDataIn = '0;
        for (int i = 0; i < 1024; i++)
            golden[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        $readmemh("dv/cpu_golden.hex", golden);
        for (int i = 0; i < 256; i++) begin
            rom[i] = golden[i];
            ram[i] = golden[256 + i];
        end
        irqCount = int'(golden['h200]);
        writeTotal = int'(golden['h300]);
        limitCycles = 40 * int'(golden['h201]) + 200 * irqCount;
        loaded = 1'b1;
        rngState = 32'd24;
        repeat (2) @(posedge CLK);
        #1 RESET = 1'b0;

        target = 0;
        for (int k = 0; k < irqCount; k++) begin
            base = 'h202 + 3 * k;
            rngState = xorshift(rngState);
            gap = 4 + int'(rngState % 12);
            idleCycles(gap, $sformatf("idle before irq %0d", k));
            @(posedge CLK);
            #1 irqRaise = golden[base][1:0];
            do @(negedge CLK); while (irqAck == '0);
            checkValue($sformatf("irq %0d ack", k), golden[base + 1], 8'(irqAck));
            @(posedge CLK);
            #1 irqRaise = '0;
            // Thread done once its writes are in
            target += int'(golden[base + 2]);
            while (writeCount < target)
                @(negedge CLK);
        end
        idleCycles(8, "final idle");
        checkValue("write count", 8'(writeTotal), 8'(writeCount));

        checkerFails = microProcessor_i.cpuChecker_i.failCount;
        errors += checkerFails;
        $display("Errors %0d, checker failures %0d, writes %0d of %0d",
                 errors, checkerFails, writeCount, writeTotal);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog, sized from the golden instruction and interrupt counts
    initial begin
        wait (loaded);
        repeat (limitCycles) @(posedge CLK);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* hdl/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::dataT   a,
    input  cpuPkg::dataT   b,
    input  cpuPkg::aluOpT  op,
    output cpuPkg::dataT   result
);

    always_comb begin
        case (op)
            // Arithmetic wraps at the data width
            cpuPkg::ALU_ADD:   result = a + b;
            cpuPkg::ALU_SUB:   result = a - b;
            cpuPkg::ALU_AND:   result = a & b;
            cpuPkg::ALU_OR:    result = a | b;
            cpuPkg::ALU_XOR:   result = a ^ b;
            cpuPkg::ALU_INC_A: result = a + cpuPkg::dataT'(1);
            cpuPkg::ALU_INC_B: result = b + cpuPkg::dataT'(1);
            // Compares give 1 or 0, for the branch test
            cpuPkg::ALU_EQ:    result = cpuPkg::dataT'(a == b);
            cpuPkg::ALU_GT:    result = cpuPkg::dataT'(a > b);
            cpuPkg::ALU_LT:    result = cpuPkg::dataT'(a < b);
            // Unused codes pass A through
            default:           result = a;
        endcase
    end

endmodule

/* hdl/cpuPkg.sv */
`include "cpu_cfg.svh"

package cpuPkg;

    typedef logic [`CPU_DATA_W-1:0] dataT;
    typedef logic [`CPU_ADDR_W-1:0] addrT;
    typedef logic [`CPU_IRQ_N-1:0] irqT;

    // Low nibble of an instruction byte
    typedef enum logic [3:0] {
        OP_READ_A = 4'h0, OP_READ_B = 4'h1, OP_WRITE_A = 4'h2, OP_WRITE_B = 4'h3,
        OP_MATHS_A = 4'h4, OP_MATHS_B = 4'h5, OP_BRANCH = 4'h6, OP_GOTO = 4'h7,
        OP_IDLE = 4'h8
    } opcodeT;

    // High nibble, codes 7, 8 and C to F pass A through
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0, ALU_SUB = 4'h1, ALU_AND = 4'h2, ALU_OR = 4'h3, ALU_XOR = 4'h4,
        ALU_INC_A = 4'h5, ALU_INC_B = 4'h6, ALU_EQ = 4'h9, ALU_GT = 4'hA, ALU_LT = 4'hB
    } aluOpT;

    typedef enum logic [4:0] {
        IDLE, THREAD_0, THREAD_1, THREAD_2,
        CHOOSE_OP,
        READ_A, READ_B, READ_0, READ_1, READ_2,
        WRITE_A, WRITE_B, WRITE_0,
        MATHS_A, MATHS_B, MATHS_0,
        BRANCH_0, BRANCH_1,
        GOTO_0, GOTO_1, GOTO_2
    } seqStateT;

endpackage

/* hdl/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 8

// Bus address driven when no access is made
`define CPU_BUS_IDLE_ADDR 'hFF

// ROM bytes holding the thread start address per interrupt line
`define CPU_VEC_A 'hFF
`define CPU_VEC_B 'hFE
`define CPU_IRQ_N 2

// Program counter steps, without and with operand byte
`define CPU_PC_STEP_ONE 1
`define CPU_PC_STEP_TWO 2

`endif

/* hdl/dataPath.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module dataPath (
    input  logic           CLK,
    input  logic           RESET,
    seqCtrlIf.dp           ctrl,
    input  cpuPkg::dataT   romData,
    input  cpuPkg::aluOpT  aluOp,
    input  cpuPkg::dataT   busDataIn,
    output cpuPkg::addrT   busAddr,
    output cpuPkg::dataT   busDataOut,
    output logic           busWe
);

    cpuPkg::dataT regA, regB;
    cpuPkg::dataT aluResult;
    // Register select, set for B and dropped once the access is done
    logic selB;

    aluUnit aluUnit_i (.a(regA), .b(regB), .op(aluOp), .result(aluResult));

    assign ctrl.aluNonZero = |aluResult;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= cpuPkg::addrT'(`CPU_BUS_IDLE_ADDR);
            busWe   <= 1'b0;
            selB    <= 1'b0;
        end else begin
            // Address only held for the cycle of the access
            busAddr <= ctrl.addrStrobe ? cpuPkg::addrT'(romData)
                                       : cpuPkg::addrT'(`CPU_BUS_IDLE_ADDR);
            busWe   <= ctrl.writeStrobe;
            if (ctrl.regSel)
                selB <= 1'b1;
            else if (ctrl.captureRead || ctrl.writeStrobe)
                selB <= 1'b0;
        end
    end

    // Register file and write data
    always_ff @(posedge CLK) begin
        if (ctrl.loadA)
            regA <= aluResult;
        else if (ctrl.captureRead && !selB)
            regA <= busDataIn;
        if (ctrl.loadB)
            regB <= aluResult;
        else if (ctrl.captureRead && selB)
            regB <= busDataIn;
        if (ctrl.writeStrobe)
            busDataOut <= selB ? regB : regA;
    end

endmodule

/* hdl/microProcessor.sv */
`timescale 1ns/1ps

module microProcessor (
    input  logic          CLK,
    input  logic          RESET,
    // Program ROM, synchronous read
    output cpuPkg::addrT  romAddr,
    input  cpuPkg::dataT  romData,
    // Data bus
    output cpuPkg::addrT  busAddr,
    input  cpuPkg::dataT  busDataIn,
    output cpuPkg::dataT  busDataOut,
    output logic          busWe,
    // Interrupt lines
    input  cpuPkg::irqT   irqRaise,
    output cpuPkg::irqT   irqAck
);

    // Program counter controls
    logic pcLoad;
    logic pcLoadVec;
    logic vecSel;
    logic pcStep;
    logic stepTwo;
    logic offsetOne;

    // ALU operation sits in the high nibble of the current ROM byte
    cpuPkg::aluOpT aluOp;
    assign aluOp = cpuPkg::aluOpT'(romData[7:4]);

    seqCtrlIf ctrlIf ();

    opSequencer opSequencer_i (
        .CLK(CLK), .RESET(RESET),
        .romData(romData), .irqRaise(irqRaise), .irqAck(irqAck),
        .pcLoad(pcLoad), .pcLoadVec(pcLoadVec), .pcStep(pcStep),
        .stepTwo(stepTwo), .offsetOne(offsetOne), .vecSel(vecSel),
        .ctrl(ctrlIf.seq)
    );

    programCounter programCounter_i (
        .CLK(CLK), .RESET(RESET),
        .pcLoad(pcLoad), .pcLoadVec(pcLoadVec), .vecSel(vecSel),
        .pcStep(pcStep), .stepTwo(stepTwo), .offsetOne(offsetOne),
        .romData(romData), .romAddr(romAddr)
    );

    dataPath dataPath_i (
        .CLK(CLK), .RESET(RESET),
        .ctrl(ctrlIf.dp), .romData(romData), .aluOp(aluOp),
        .busDataIn(busDataIn), .busAddr(busAddr), .busDataOut(busDataOut), .busWe(busWe)
    );

endmodule

/* hdl/opSequencer.sv */
`timescale 1ns/1ps

module opSequencer (
    input  logic          CLK,
    input  logic          RESET,
    input  cpuPkg::dataT  romData,
    input  cpuPkg::irqT   irqRaise,
    output cpuPkg::irqT   irqAck,
    output logic          pcLoad,
    output logic          pcLoadVec,
    output logic          pcStep,
    output logic          stepTwo,
    output logic          offsetOne,
    output logic          vecSel,
    seqCtrlIf.seq         ctrl
);

    cpuPkg::seqStateT state, nextState;
    cpuPkg::irqT nextAck;
    cpuPkg::opcodeT opcode;

    // Valid as an opcode only in CHOOSE_OP
    assign opcode = cpuPkg::opcodeT'(romData[3:0]);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= cpuPkg::IDLE;
            irqAck <= '0;
        end else begin
            state  <= nextState;
            irqAck <= nextAck;
        end
    end

    always_comb begin
        // Everything idles unless a state asks for it
        nextState = state;
        nextAck = '0;
        pcLoad = 1'b0;
        pcLoadVec = 1'b0;
        vecSel = 1'b0;
        pcStep = 1'b0;
        stepTwo = 1'b0;
        offsetOne = 1'b0;
        ctrl.loadA = 1'b0;
        ctrl.loadB = 1'b0;
        ctrl.captureRead = 1'b0;
        ctrl.regSel = 1'b0;
        ctrl.addrStrobe = 1'b0;
        ctrl.writeStrobe = 1'b0;

        case (state)
            //////////////////////////////
            // Thread start
            cpuPkg::IDLE: begin
                // Line 0 has priority
                if (irqRaise[0] || irqRaise[1]) begin
                    nextState = cpuPkg::THREAD_0;
                    pcLoadVec = 1'b1;
                    vecSel = !irqRaise[0];
                    nextAck = irqRaise[0] ? 2'b01 : 2'b10;
                end
            end
            // Vector byte on its way from ROM
            cpuPkg::THREAD_0: nextState = cpuPkg::THREAD_1;
            cpuPkg::THREAD_1: begin
                pcLoad = 1'b1;
                nextState = cpuPkg::THREAD_2;
            end
            // First opcode fetch in flight
            cpuPkg::THREAD_2: nextState = cpuPkg::CHOOSE_OP;

            //////////////////////////////
            // Decode, and point the ROM at the operand byte
            cpuPkg::CHOOSE_OP: begin
                offsetOne = 1'b1;
                case (opcode)
                    cpuPkg::OP_READ_A:  nextState = cpuPkg::READ_A;
                    cpuPkg::OP_READ_B:  nextState = cpuPkg::READ_B;
                    cpuPkg::OP_WRITE_A: nextState = cpuPkg::WRITE_A;
                    cpuPkg::OP_WRITE_B: nextState = cpuPkg::WRITE_B;
                    cpuPkg::OP_MATHS_A: nextState = cpuPkg::MATHS_A;
                    cpuPkg::OP_MATHS_B: nextState = cpuPkg::MATHS_B;
                    cpuPkg::OP_BRANCH:  nextState = cpuPkg::BRANCH_0;
                    cpuPkg::OP_GOTO:    nextState = cpuPkg::GOTO_0;
                    // Return and unknown codes end the thread
                    default:            nextState = cpuPkg::IDLE;
                endcase
            end

            //////////////////////////////
            // Memory access
            cpuPkg::READ_A, cpuPkg::READ_B: begin
                ctrl.regSel = (state == cpuPkg::READ_B);
                nextState = cpuPkg::READ_0;
            end
            // Operand byte is the read address
            cpuPkg::READ_0: begin
                ctrl.addrStrobe = 1'b1;
                nextState = cpuPkg::READ_1;
            end
            // RAM answers next cycle, next opcode fetched meanwhile
            cpuPkg::READ_1: begin
                pcStep = 1'b1;
                stepTwo = 1'b1;
                nextState = cpuPkg::READ_2;
            end
            cpuPkg::READ_2: begin
                ctrl.captureRead = 1'b1;
                nextState = cpuPkg::CHOOSE_OP;
            end
            cpuPkg::WRITE_A, cpuPkg::WRITE_B: begin
                ctrl.regSel = (state == cpuPkg::WRITE_B);
                pcStep = 1'b1;
                stepTwo = 1'b1;
                nextState = cpuPkg::WRITE_0;
            end
            cpuPkg::WRITE_0: begin
                ctrl.addrStrobe = 1'b1;
                ctrl.writeStrobe = 1'b1;
                nextState = cpuPkg::CHOOSE_OP;
            end

            //////////////////////////////
            // ALU and flow control
            cpuPkg::MATHS_A, cpuPkg::MATHS_B: begin
                ctrl.loadA = (state == cpuPkg::MATHS_A);
                ctrl.loadB = (state == cpuPkg::MATHS_B);
                pcStep = 1'b1;
                nextState = cpuPkg::MATHS_0;
            end
            cpuPkg::MATHS_0: nextState = cpuPkg::CHOOSE_OP;
            // Taken branch steps onto the operand and reuses the goto states
            cpuPkg::BRANCH_0: begin
                pcStep = 1'b1;
                stepTwo = !ctrl.aluNonZero;
                nextState = ctrl.aluNonZero ? cpuPkg::GOTO_0 : cpuPkg::BRANCH_1;
            end
            cpuPkg::BRANCH_1: nextState = cpuPkg::CHOOSE_OP;
            cpuPkg::GOTO_0: nextState = cpuPkg::GOTO_1;
            cpuPkg::GOTO_1: begin
                pcLoad = 1'b1;
                nextState = cpuPkg::GOTO_2;
            end
            cpuPkg::GOTO_2: nextState = cpuPkg::CHOOSE_OP;
            default: nextState = cpuPkg::IDLE;
        endcase
    end

endmodule

/* hdl/programCounter.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module programCounter (
    input  logic          CLK,
    input  logic          RESET,
    input  logic          pcLoad,
    input  logic          pcLoadVec,
    input  logic          vecSel,
    input  logic          pcStep,
    input  logic          stepTwo,
    input  logic          offsetOne,
    input  cpuPkg::dataT  romData,
    output cpuPkg::addrT  romAddr
);

    cpuPkg::addrT pc;
    // Set for one cycle to fetch the operand byte
    logic offset;

    assign romAddr = pc + cpuPkg::addrT'(offset);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc     <= '0;
            offset <= 1'b0;
        end else begin
            offset <= offsetOne;
            if (pcLoadVec)
                pc <= vecSel ? cpuPkg::addrT'(`CPU_VEC_B) : cpuPkg::addrT'(`CPU_VEC_A);
            else if (pcLoad)
                pc <= cpuPkg::addrT'(romData);
            else if (pcStep)
                pc <= pc + (stepTwo ? cpuPkg::addrT'(`CPU_PC_STEP_TWO)
                                    : cpuPkg::addrT'(`CPU_PC_STEP_ONE));
        end
    end

endmodule

/* hdl/seqCtrlIf.sv */
`timescale 1ns/1ps

// Commands from the sequencer to the datapath, all single-cycle pulses or levels
interface seqCtrlIf;
    logic loadA;
    logic loadB;
    logic captureRead;
    // 1 selects register B for the next read or write
    logic regSel;
    logic addrStrobe;
    logic writeStrobe;
    // Branch condition back to the sequencer
    logic aluNonZero;

    modport seq (
        output loadA, loadB, captureRead, regSel, addrStrobe, writeStrobe,
        input aluNonZero
    );

    modport dp (
        input loadA, loadB, captureRead, regSel, addrStrobe, writeStrobe,
        output aluNonZero
    );
endinterface

/* run.sh */
#!/usr/bin/env bash
# Build and run the microProcessor testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f verilog.f --top-module tbMicroProcessor -Mdir "$OBJ" -o simv; then
    echo "Verilator build failed"
    exit 1
fi

if ! "$OBJ/simv" +verilator+error+limit+1000 > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
exit 1

/* verilog.f */
+incdir+hdl
hdl/cpuPkg.sv
hdl/seqCtrlIf.sv
hdl/aluUnit.sv
hdl/programCounter.sv
hdl/dataPath.sv
hdl/opSequencer.sv
hdl/microProcessor.sv
dv/cpu_checker.sv
dv/tbMicroProcessor.sv
